//--- hw/lineCodePkg.sv
package lineCodePkg;

    // ########################################
    // character and codeword types
    // ########################################

    typedef struct packed {
        logic [7:0] data;
        logic       isK;
    } txChar_t;

    typedef struct packed {
        logic [7:0] data;
        logic       isK;
        logic       codeErr;
        logic       dispErr;
    } rxChar_t;

    // the 6-bit sub-block sits in bits 9..4, the 4-bit sub-block in bits 3..0.
    typedef logic [9:0] codeWord_t;

    typedef enum logic [1:0] {
        modeData     = 2'd0,
        modeIdle     = 2'd1,
        modeLoopback = 2'd2
    } linkMode_t;

    typedef struct packed {
        linkMode_t mode;
    } linkCfg_t;

    // ########################################
    // code constants
    // ########################################

    localparam txChar_t commaK285 = '{data: 8'hBC, isK: 1'b1};
    localparam int errCountWidth = 8;

    // K.28 6b code in its RD- form.
    localparam logic [5:0] k28Code6 = 6'b001111;

    // both forms of the K28.5 comma.
    localparam codeWord_t k285RdMinus = 10'b0011111010;
    localparam codeWord_t k285RdPlus = 10'b1100000101;

    // the 5b/6b table holds the RD- codes; RD+ complements the unbalanced codes and D.7.
    function automatic logic [5:0] code6RdMinus(input logic [4:0] x);
        logic [5:0] code;
        case (x)
            5'd0:  code = 6'b100111;
            5'd1:  code = 6'b011101;
            5'd2:  code = 6'b101101;
            5'd3:  code = 6'b110001;
            5'd4:  code = 6'b110101;
            5'd5:  code = 6'b101001;
            5'd6:  code = 6'b011001;
            5'd7:  code = 6'b111000;
            5'd8:  code = 6'b111001;
            5'd9:  code = 6'b100101;
            5'd10: code = 6'b010101;
            5'd11: code = 6'b110100;
            5'd12: code = 6'b001101;
            5'd13: code = 6'b101100;
            5'd14: code = 6'b011100;
            5'd15: code = 6'b010111;
            5'd16: code = 6'b011011;
            5'd17: code = 6'b100011;
            5'd18: code = 6'b010011;
            5'd19: code = 6'b110010;
            5'd20: code = 6'b001011;
            5'd21: code = 6'b101010;
            5'd22: code = 6'b011010;
            5'd23: code = 6'b111010;
            5'd24: code = 6'b110011;
            5'd25: code = 6'b100110;
            5'd26: code = 6'b010110;
            5'd27: code = 6'b110110;
            5'd28: code = 6'b001110;
            5'd29: code = 6'b101110;
            5'd30: code = 6'b011110;
            default: code = 6'b101011;
        endcase
        return code;
    endfunction

    // the 3b/4b data table holds the RD- codes with the primary D.x.7 code.
    function automatic logic [3:0] code4RdMinus(input logic [2:0] y);
        logic [3:0] code;
        case (y)
            3'd0: code = 4'b1011;
            3'd1: code = 4'b1001;
            3'd2: code = 4'b0101;
            3'd3: code = 4'b1100;
            3'd4: code = 4'b1101;
            3'd5: code = 4'b1010;
            3'd6: code = 4'b0110;
            default: code = 4'b1110;
        endcase
        return code;
    endfunction

endpackage

//--- hw/encoder8b10b.sv
`timescale 1ns/100ps

module encoder8b10b import lineCodePkg::*; (
    input  logic      BitCLK_10,
    input  logic      Reset,
    input  txChar_t   TxChar,
    input  logic      idleFill,
    output codeWord_t TxParallel_10
);

    // runDisp is high while the running disparity is positive.
    logic       runDisp;
    txChar_t    charIn;
    logic [4:0] x5;
    logic [2:0] y3;
    logic [5:0] base6;
    logic [5:0] code6;
    logic       rdMid;
    logic       useAlt;
    logic       flip4;
    logic [3:0] base4;
    logic [3:0] code4;
    logic       rdNext;

    assign charIn = idleFill ? commaK285 : TxChar;
    assign x5 = charIn.data[4:0];
    assign y3 = charIn.data[7:5];

    // ########################################
    // 5b/6b sub-block
    // ########################################

    always_comb begin
        if (charIn.isK && x5 == 5'd28) begin
            base6 = k28Code6;
        end else begin
            base6 = code6RdMinus(x5);
        end
        if (runDisp && ($countones(base6) != 3 || base6 == 6'b111000)) begin
            code6 = ~base6;
        end else begin
            code6 = base6;
        end
        rdMid = runDisp ^ ($countones(code6) != 3);
    end

    // ########################################
    // 3b/4b sub-block
    // ########################################

    // the alternate D.x.7 code avoids a run of five equal bits across the sub-blocks.
    assign useAlt = rdMid ? (x5 == 5'd11 || x5 == 5'd13 || x5 == 5'd14)
                          : (x5 == 5'd17 || x5 == 5'd18 || x5 == 5'd20);

    // control codes always swap form with disparity, data codes only for y of 0, 3, 4 and 7.
    assign flip4 = charIn.isK || y3 == 3'd0 || y3 == 3'd3 || y3 == 3'd4 || y3 == 3'd7;

    always_comb begin
        base4 = code4RdMinus(y3);
        if (charIn.isK && (y3 == 3'd1 || y3 == 3'd2 || y3 == 3'd5 || y3 == 3'd6)) begin
            base4 = ~base4;
        end
        if (y3 == 3'd7 && (charIn.isK || useAlt)) begin
            base4 = 4'b0111;
        end
        code4 = (rdMid && flip4) ? ~base4 : base4;
        rdNext = rdMid ^ ($countones(code4) != 2);
    end

    always_ff @(posedge BitCLK_10, negedge Reset) begin
        if (!Reset) begin
            runDisp <= 1'b0;
            TxParallel_10 <= '0;
        end else begin
            runDisp <= rdNext;
            TxParallel_10 <= {code6, code4};
        end
    end

endmodule

//--- hw/decoder10b8b.sv
`timescale 1ns/100ps

module decoder10b8b import lineCodePkg::*; (
    input  logic      BitCLK_10,
    input  logic      Reset,
    input  codeWord_t RxParallel_10,
    output rxChar_t   RxChar
);

    logic       runDisp;
    logic [5:0] raw6;
    logic [3:0] raw4;
    logic [2:0] ones6;
    logic [2:0] ones4;
    logic [5:0] norm6;
    logic [3:0] adj4;
    logic [3:0] norm4;
    logic       isK28;
    logic       valid6;
    logic       valid4;
    logic       alt4;
    logic       kx7;
    logic       altOk;
    logic [4:0] x5;
    logic [2:0] y3;
    logic       codeErr;
    logic       dispErr;
    logic       rdMid;
    logic       rdNext;

    assign raw6 = RxParallel_10[9:4];
    assign raw4 = RxParallel_10[3:0];
    assign ones6 = 3'($countones(raw6));

    // ########################################
    // inverse tables
    // ########################################

    // codes are folded back to their RD- form before the lookup.
    always_comb begin
        if (ones6 == 3'd2) begin
            norm6 = ~raw6;
        end else if (raw6 == 6'b000111) begin
            norm6 = 6'b111000;
        end else begin
            norm6 = raw6;
        end
        isK28 = norm6 == k28Code6;
        valid6 = isK28;
        x5 = isK28 ? 5'd28 : 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (code6RdMinus(5'(i)) == norm6) begin
                valid6 = 1'b1;
                x5 = 5'(i);
            end
        end
    end

    // after K.28 in its RD+ form the balanced control codes come inverted.
    assign adj4 = (isK28 && ones6 == 3'd2) ? ~raw4 : raw4;
    assign ones4 = 3'($countones(adj4));

    always_comb begin
        if (ones4 == 3'd1) begin
            norm4 = ~adj4;
        end else if (adj4 == 4'b0011) begin
            norm4 = 4'b1100;
        end else begin
            norm4 = adj4;
        end
        alt4 = norm4 == 4'b0111;
        valid4 = alt4;
        y3 = alt4 ? 3'd7 : 3'd0;
        for (int j = 0; j < 8; j++) begin
            if (code4RdMinus(3'(j)) == norm4) begin
                valid4 = 1'b1;
                y3 = 3'(j);
            end
        end
    end

    assign kx7 = alt4 && !isK28
                 && (x5 == 5'd23 || x5 == 5'd27 || x5 == 5'd29 || x5 == 5'd30);
    assign altOk = isK28 || kx7 || x5 == 5'd11 || x5 == 5'd13 || x5 == 5'd14
                   || x5 == 5'd17 || x5 == 5'd18 || x5 == 5'd20;
    assign codeErr = !valid6 || !valid4 || (alt4 && !altOk) || (isK28 && y3 == 3'd7 && !alt4);

    // ########################################
    // running disparity
    // ########################################

    // an unbalanced sub-block must point away from the current disparity.
    always_comb begin
        dispErr = 1'b0;
        rdMid = runDisp;
        if (ones6 != 3'd3) begin
            dispErr = (ones6 > 3'd3) == runDisp;
            rdMid = ones6 > 3'd3;
        end
        rdNext = rdMid;
        if (3'($countones(raw4)) != 3'd2) begin
            dispErr = dispErr || ((3'($countones(raw4)) > 3'd2) == rdMid);
            rdNext = 3'($countones(raw4)) > 3'd2;
        end
    end

    always_ff @(posedge BitCLK_10, negedge Reset) begin
        if (!Reset) begin
            runDisp <= 1'b0;
            RxChar <= '0;
        end else begin
            runDisp <= rdNext;
            RxChar <= '{data: {y3, x5}, isK: isK28 || kx7, codeErr: codeErr, dispErr: dispErr};
        end
    end

endmodule

//--- hw/linkConfig.sv
`timescale 1ns/100ps

module linkConfig import lineCodePkg::*; (
    input  logic                     BitCLK_10,
    input  logic                     Reset,
    input  logic                     CfgWrite,
    input  linkMode_t                CfgMode,
    input  rxChar_t                  RxChar,
    output linkCfg_t                 LinkCfg,
    output logic [errCountWidth-1:0] ErrCount
);

    logic rxBad;
    logic countFull;

    assign rxBad = RxChar.codeErr || RxChar.dispErr;
    assign countFull = &ErrCount;

    always_ff @(posedge BitCLK_10, negedge Reset) begin
        if (!Reset) begin
            LinkCfg.mode <= modeData;
        end else if (CfgWrite) begin
            LinkCfg.mode <= CfgMode;
        end
    end

    // a write wins over an error in the same cycle.
    always_ff @(posedge BitCLK_10, negedge Reset) begin
        if (!Reset) begin
            ErrCount <= '0;
        end else if (CfgWrite) begin
            ErrCount <= '0;
        end else if (rxBad && !countFull) begin
            ErrCount <= ErrCount + 1'b1;
        end
    end

endmodule

//--- hw/codecLink.sv
`timescale 1ns/100ps

module codecLink import lineCodePkg::*; (
    input  logic                     BitCLK_10,
    input  logic                     Reset,
    input  txChar_t                  TxChar,
    input  codeWord_t                RxParallel_10,
    input  logic                     CfgWrite,
    input  linkMode_t                CfgMode,
    output codeWord_t                TxParallel_10,
    output rxChar_t                  RxChar,
    output logic [errCountWidth-1:0] ErrCount
);

    linkCfg_t  linkCfg;
    logic      idleFill;
    codeWord_t decoderIn;

    assign idleFill = linkCfg.mode == modeIdle;

    // in loopback the decoder listens to our own transmitter.
    assign decoderIn = (linkCfg.mode == modeLoopback) ? TxParallel_10 : RxParallel_10;

    encoder8b10b encoder_i (
        .BitCLK_10     (BitCLK_10),
        .Reset         (Reset),
        .TxChar        (TxChar),
        .idleFill      (idleFill),
        .TxParallel_10 (TxParallel_10)
    );

    decoder10b8b decoder_i (
        .BitCLK_10     (BitCLK_10),
        .Reset         (Reset),
        .RxParallel_10 (decoderIn),
        .RxChar        (RxChar)
    );

    linkConfig linkConfig_i (
        .BitCLK_10 (BitCLK_10),
        .Reset     (Reset),
        .CfgWrite  (CfgWrite),
        .CfgMode   (CfgMode),
        .RxChar    (RxChar),
        .LinkCfg   (linkCfg),
        .ErrCount  (ErrCount)
    );

endmodule

//--- sim/codecLink_assert.sv
`timescale 1ns/100ps

module codecLinkAssert import lineCodePkg::*; (
    input logic                     BitCLK_10,
    input logic                     Reset,
    input logic                     CfgWrite,
    input linkMode_t                mode,
    input codeWord_t                TxParallel_10,
    input rxChar_t                  RxChar,
    input logic [errCountWidth-1:0] ErrCount
);

    clearOnWrite: assert property (@(posedge BitCLK_10) disable iff (!Reset)
        CfgWrite |=> ErrCount == '0) else $error("ErrCount not cleared by a write");

    noDecrease: assert property (@(posedge BitCLK_10) disable iff (!Reset)
        !CfgWrite |=> ErrCount >= $past(ErrCount)) else $error("ErrCount decreased");

    // idle fill sends only the comma, in either disparity form.
    idleComma: assert property (@(posedge BitCLK_10) disable iff (!Reset)
        mode == modeIdle |=> (TxParallel_10 == k285RdMinus || TxParallel_10 == k285RdPlus))
        else $error("idle codeword is not K28.5");

    cleanAfterReset: assert property (@(posedge BitCLK_10)
        $rose(Reset) |=> (!RxChar.codeErr && !RxChar.dispErr))
        else $error("RxChar flags set after reset");

endmodule

bind codecLink codecLinkAssert codecLinkAssert_i (
    .BitCLK_10     (BitCLK_10),
    .Reset         (Reset),
    .CfgWrite      (CfgWrite),
    .mode          (linkCfg.mode),
    .TxParallel_10 (TxParallel_10),
    .RxChar        (RxChar),
    .ErrCount      (ErrCount)
);

//--- sim/codecLinkTb.sv
`timescale 1ns/100ps

module codecLinkTb import lineCodePkg::*; ();

    logic                     BitCLK_10 = 1'b0;
    logic                     Reset;
    txChar_t                  TxChar;
    codeWord_t                RxParallel_10;
    logic                     CfgWrite;
    linkMode_t                CfgMode;
    codeWord_t                TxParallel_10;
    rxChar_t                  RxChar;
    logic [errCountWidth-1:0] ErrCount;
    int                       fallCount;

    codecLink codecLink_i (.*);

    always #5 BitCLK_10 = ~BitCLK_10;

    initial fallCount = 0;
    always @(negedge BitCLK_10) fallCount <= fallCount + 1;

    // ########################################
    // helpers
    // ########################################

    task automatic stopOnFailure(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // returns shortly after the next falling clock edge.
    task automatic waitFalling();
        int target;
        int guard;
        target = fallCount + 1;
        guard = 0;
        while (fallCount < target) begin
            #1;
            guard++;
            if (guard > 50) begin
                stopOnFailure("timeout: the clock stopped toggling");
            end
        end
    endtask

    task automatic reportMismatch(input string what);
        $display("** Error at %0d ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic checkCodeWord(input codeWord_t got, input codeWord_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("TxParallel_10 is %h, expected %h", got, exp));
        end
    endtask

    task automatic checkRxChar(input rxChar_t got, input rxChar_t exp);
        if (got !== exp) begin
            reportMismatch($sformatf("RxChar is %h, expected %h", got, exp));
        end
    endtask

    task automatic checkCount(input logic [errCountWidth-1:0] got,
                              input logic [errCountWidth-1:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("ErrCount is %0d, expected %0d", got, exp));
        end
    endtask

    // ########################################
    // stimulus
    // ########################################

    initial begin
        int                       fd;
        int                       items;
        int                       rep;
        string                    line;
        logic [3:0]               wr;
        logic [3:0]               mode;
        logic [7:0]               txData;
        logic [3:0]               txK;
        codeWord_t                rxWord;
        codeWord_t                expTx;
        logic [7:0]               expData;
        logic [2:0]               expFlags;
        logic [errCountWidth-1:0] expCount;
        logic [2:0]               mask;

        Reset = 1'b0;
        TxChar = '0;
        RxParallel_10 = '0;
        CfgWrite = 1'b0;
        CfgMode = modeData;
        fd = $fopen("sim/codecLink_testdata.txt", "r");
        if (fd == 0) begin
            stopOnFailure("could not open sim/codecLink_testdata.txt");
        end
        waitFalling();
        waitFalling();
        Reset = 1'b1;
        checkCodeWord(TxParallel_10, '0);
        checkRxChar(RxChar, '0);
        checkCount(ErrCount, '0);

        while (!$feof(fd)) begin
            line = "";
            items = $fgets(line, fd);
            items = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", rep, wr, mode,
                            txData, txK, rxWord, expTx, expData, expFlags, expCount, mask);
            // comment lines and blank lines yield fewer fields.
            if (items == 11) begin
                for (int r = 0; r < rep; r++) begin
                    CfgWrite = wr[0];
                    CfgMode = linkMode_t'(mode[1:0]);
                    TxChar = '{data: txData, isK: txK[0]};
                    RxParallel_10 = rxWord;
                    waitFalling();
                    if (r == rep - 1) begin
                        if (mask[0]) begin
                            checkCodeWord(TxParallel_10, expTx);
                        end
                        if (mask[1]) begin
                            checkRxChar(RxChar, '{data: expData, isK: expFlags[2],
                                                  codeErr: expFlags[1], dispErr: expFlags[0]});
                        end
                        if (mask[2]) begin
                            checkCount(ErrCount, expCount);
                        end
                    end
                end
            end
        end
        $fclose(fd);
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- sim/codecLink_testdata.txt
# rep(dec) wr mode txData txK rxWord | expTx expRxData expFlags(isK,codeErr,dispErr) expCount mask
# expected values are the outputs after the rising edge that samples the line; mask 1=tx 2=rx 4=cnt
1 0 0 00 0 319 274 23 0 00 7
1 0 0 E7 0 319 38E 23 0 00 7
1 0 0 F1 0 319 231 23 0 00 7
1 0 0 F1 0 319 237 23 0 00 7
1 0 0 EB 0 319 348 23 0 00 7
1 0 0 BC 1 319 0FA 23 0 00 7
1 0 0 BC 1 319 305 23 0 00 7
1 0 0 FC 1 319 0F8 23 0 00 7
1 0 0 F7 1 319 3A8 23 0 00 7
1 0 0 1C 1 319 0F4 23 0 00 7
1 0 0 7F 0 319 2B3 23 0 00 7
1 0 0 C5 0 319 296 23 0 00 7
1 0 0 23 0 319 319 23 0 00 7
1 0 0 80 0 319 18D 23 0 00 7
1 0 0 42 0 319 125 23 0 00 7
1 0 0 23 0 000 319 00 3 00 7
1 0 0 23 0 18B 319 00 1 01 7
1 0 0 23 0 319 319 23 0 02 7
1 0 0 23 0 319 319 23 0 02 7
1 1 0 23 0 319 319 23 0 00 7
1 1 1 23 0 319 319 23 0 00 7
1 0 1 55 0 319 0FA 23 0 00 7
1 0 1 00 0 319 305 23 0 00 7
1 0 1 00 0 319 0FA 23 0 00 7
1 1 2 23 0 319 305 23 0 00 7
1 0 2 00 0 000 274 BC 4 00 7
1 0 2 E7 0 000 38E 00 0 00 7
1 0 2 42 0 000 125 E7 0 00 7
1 0 2 23 0 000 319 42 0 00 7
1 1 0 23 0 000 319 23 0 00 7
300 0 0 23 0 000 319 00 3 FF 7
1 0 0 23 0 319 319 23 0 FF 7
1 1 0 23 0 319 319 23 0 00 7
1 0 0 23 0 319 319 23 0 00 7

//--- flist.f
hw/lineCodePkg.sv
hw/encoder8b10b.sv
hw/decoder10b8b.sv
hw/linkConfig.sv
hw/codecLink.sv
sim/codecLink_assert.sv
sim/codecLinkTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module codecLinkTb -f flist.f -o codecLinkSim
./obj_dir/codecLinkSim
